// File: enc_pkg.sv
`default_nettype none
// ----------------------------------------
// widths, limits, typedefs and period
// counter states for one encoder channel
// ----------------------------------------

package enc_pkg;

   // ----------------------------------------
   // widths and filter depth
   // ----------------------------------------
   localparam int period_w    = 22;  // clk_fast cycles between steps
   localparam int pos_w       = 16;  // signed position
   localparam int err_w       = 8;   // illegal transition count
   localparam int sync_stages = 2;   // flops per raw line
   localparam int filt_len    = 2;   // equal samples before a line moves

   // ----------------------------------------
   // typedefs
   // ----------------------------------------
   typedef logic        [period_w-1:0] period_t;   // cycle count
   typedef logic signed [pos_w-1:0]    pos_t;      // position, wraps
   typedef logic        [err_w-1:0]    err_cnt_t;  // saturating count
   typedef logic        [1:0]          quad_t;     // code {a, b}

   localparam period_t  period_max = '1;  // saturation and overflow marker
   localparam err_cnt_t err_max    = '1;  // error count stops here

   // period counter reference tracking
   typedef enum logic [1:0] {
      idle,     // no step since reset
      armed,    // one step seen, measuring
      running   // measurement valid
   } step_state_e;

endpackage

`default_nettype wire

// File: enc_input_sync.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// synchronizer and glitch filter for the
// raw a and b encoder lines
// ----------------------------------------

module enc_input_sync import enc_pkg::*; (
   input  wire  clk_fast,  // sample clock
   input  wire  reset,     // async, active low
   input  wire  a,         // raw line a, asynchronous
   input  wire  b,         // raw line b, asynchronous
   output logic a_filt,    // filtered a
   output logic b_filt     // filtered b
);

   // sync flops plus the extra history the filter window needs
   localparam int chain_len = sync_stages + filt_len - 1;

   logic [1:0] line_in;    // {a, b} raw
   logic [1:0] line_filt;  // {a, b} filtered

   assign line_in = {a, b};

   // ----------------------------------------
   // one chain and filter per line
   // ----------------------------------------
   for (genvar i = 0; i < 2; i++) begin : g_line
      logic [chain_len-1:0] sh;    // bit 0 is the first sync flop
      logic [filt_len-1:0]  win;   // newest filt_len synced samples
      logic                 hold;  // level kept while window disagrees

      // window starts at the last sync flop
      assign win = sh[chain_len-1 -: filt_len];

      always_ff @(posedge clk_fast or negedge reset) begin
         if (!reset) begin
            sh   <= '0;
            hold <= 1'b0;
         end else begin
            sh   <= {sh[chain_len-2:0], line_in[i]};  // shift toward window
            hold <= line_filt[i];                    // remember last output
         end
      end

      // move only when the whole window agrees
      assign line_filt[i] = (&win) ? 1'b1 :
                            (|win) ? hold : 1'b0;
   end

   assign a_filt = line_filt[1];
   assign b_filt = line_filt[0];

endmodule

`default_nettype wire

// File: enc_quad_decoder.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// quadrature decoder with step, direction,
// position and illegal transition count
// ----------------------------------------

module enc_quad_decoder import enc_pkg::*; (
   input  wire      clk_fast,    // decode clock
   input  wire      reset,       // async, active low
   input  wire      a_filt,      // filtered line a
   input  wire      b_filt,      // filtered line b
   output logic     step,        // one cycle per legal transition
   output logic     dir,         // 1 forward, 0 backward
   output pos_t     position,    // signed step count
   output logic     quad_error,  // one cycle per double change
   output err_cnt_t err_count    // saturating illegal count
);

   quad_t code;       // current {a, b}
   quad_t prev_code;  // code held from last cycle
   logic  is_fwd;     // one step forward
   logic  is_bwd;     // one step backward
   logic  is_bad;     // both bits flipped

   // ----------------------------------------
   // forward order 00 -> 10 -> 11 -> 01 -> 00
   // ----------------------------------------
   function automatic quad_t fwd_next(input quad_t c);
      case (c)
         2'b00:   return 2'b10;
         2'b10:   return 2'b11;
         2'b11:   return 2'b01;
         default: return 2'b00;
      endcase
   endfunction

   assign code = {a_filt, b_filt};

   // no change matches none of these
   assign is_fwd = (code == fwd_next(prev_code));
   assign is_bwd = (prev_code == fwd_next(code));
   assign is_bad = (code == ~prev_code);

   // ----------------------------------------
   // step, dir and error pulses
   // ----------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         prev_code  <= '0;  // filtered lines reset to 0
         step       <= 1'b0;
         dir        <= 1'b0;
         quad_error <= 1'b0;
      end else begin
         prev_code  <= code;
         step       <= is_fwd | is_bwd;
         quad_error <= is_bad;
         if (is_fwd | is_bwd) begin
            dir <= is_fwd;  // held between steps
         end
      end
   end

   // ----------------------------------------
   // position and error count
   // ----------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         position <= '0;
      end else if (is_fwd) begin
         position <= position + pos_t'(1);  // wraps at the top
      end else if (is_bwd) begin
         position <= position - pos_t'(1);  // goes negative past 0
      end
   end

   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         err_count <= '0;
      end else if (is_bad && err_count != err_max) begin
         err_count <= err_count + err_cnt_t'(1);  // stops at err_max
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   step_err_excl: assert property (@(posedge clk_fast) disable iff (!reset)
      !(step && quad_error));

endmodule

`default_nettype wire

// File: enc_period_counter.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// step period counter with saturation,
// reversal flag and larger-of selection
// ----------------------------------------

module enc_period_counter import enc_pkg::*; (
   input  wire     clk_fast,      // counted clock
   input  wire     reset,         // async, active low
   input  wire     step,          // one cycle per encoder step
   input  wire     dir,           // direction of that step
   output period_t period,        // larger of latched and running count
   output period_t latched,       // spacing of the last two steps
   output logic    dir_changed,   // last step reversed direction
   output logic    period_valid   // new latched value this cycle
);

   step_state_e state;     // reference step tracking
   period_t     cnt;       // cycles since last step
   period_t     cnt_inc;   // cnt + 1, saturated
   logic        prev_dir;  // dir of the previous step
   logic        has_ref;   // a previous step exists
   logic        rev;       // this step reverses direction

   assign cnt_inc = (cnt == period_max) ? period_max : cnt + period_t'(1);
   assign has_ref = (state != idle);
   assign rev     = (dir != prev_dir);

   // ----------------------------------------
   // state machine
   // ----------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         state <= idle;
      end else if (step) begin
         case (state)
            idle:    state <= armed;    // first step only arms
            armed:   state <= running;  // first full measurement
            default: state <= running;
         endcase
      end
   end

   // ----------------------------------------
   // running count
   // ----------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         cnt <= '0;
      end else if (step) begin
         cnt <= '0;       // restart at each step
      end else begin
         cnt <= cnt_inc;  // holds at period_max
      end
   end

   // ----------------------------------------
   // latch on step
   // ----------------------------------------
   always_ff @(posedge clk_fast or negedge reset) begin
      if (!reset) begin
         latched      <= '0;
         dir_changed  <= 1'b0;
         prev_dir     <= 1'b0;
         period_valid <= 1'b0;
      end else begin
         period_valid <= step && has_ref;  // no report for the arming step
         if (step) begin
            prev_dir <= dir;
            if (has_ref && rev) begin
               latched     <= period_max;  // reversal never looks fast
               dir_changed <= 1'b1;
            end else if (has_ref) begin
               latched     <= cnt_inc;     // equals step spacing
               dir_changed <= 1'b0;
            end
         end
      end
   end

   // report whichever is larger so a stalled encoder shows a long period
   assign period = (latched > cnt) ? latched : cnt;

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // count stops at period_max and never rolls over between steps
   cnt_bound: assert property (@(posedge clk_fast) disable iff (!reset)
      !$past(step) |-> cnt >= $past(cnt));

   valid_after_step: assert property (@(posedge clk_fast) disable iff (!reset)
      period_valid |-> $past(step));

   period_ge_latched: assert property (@(posedge clk_fast) disable iff (!reset)
      period >= latched);

endmodule

`default_nettype wire

// File: enc_channel_top.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// one encoder channel with sync, decoder
// and period counter
// ----------------------------------------

module enc_channel_top import enc_pkg::*; (
   input  wire      clk_fast,      // single clock domain
   input  wire      reset,         // async, active low
   input  wire      a,             // raw encoder line a
   input  wire      b,             // raw encoder line b
   output logic     step,          // legal step pulse
   output logic     dir,           // direction of last step
   output pos_t     position,      // signed position
   output logic     quad_error,    // illegal transition pulse
   output err_cnt_t err_count,     // saturating illegal count
   output period_t  period,        // larger of latched and running
   output period_t  latched,       // last step spacing
   output logic     dir_changed,   // last step reversed
   output logic     period_valid   // latched updated
);

   logic a_filt;  // filtered a into decoder
   logic b_filt;  // filtered b into decoder

   // ----------------------------------------
   // pin to filtered line, 3 cycles
   // ----------------------------------------
   enc_input_sync sync_i (
      .clk_fast (clk_fast),
      .reset    (reset),
      .a        (a),
      .b        (b),
      .a_filt   (a_filt),
      .b_filt   (b_filt)
   );

   // filtered line to step and position, 1 cycle
   enc_quad_decoder dec_i (
      .clk_fast   (clk_fast),
      .reset      (reset),
      .a_filt     (a_filt),
      .b_filt     (b_filt),
      .step       (step),
      .dir        (dir),
      .position   (position),
      .quad_error (quad_error),
      .err_count  (err_count)
   );

   // step to period report, 1 cycle
   enc_period_counter per_i (
      .clk_fast     (clk_fast),
      .reset        (reset),
      .step         (step),
      .dir          (dir),
      .period       (period),
      .latched      (latched),
      .dir_changed  (dir_changed),
      .period_valid (period_valid)
   );

endmodule

`default_nettype wire

// File: enc_checker.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// pin level model of the encoder channel
// and comparison with the DUT outputs
// ----------------------------------------

module enc_checker import enc_pkg::*; (
   input  wire           clk_fast,
   input  wire           reset,
   input  wire           a,             // pins as driven
   input  wire           b,
   input  wire           step,
   input  wire           dir,
   input  wire pos_t     position,
   input  wire           quad_error,
   input  wire err_cnt_t err_count,
   input  wire period_t  period,
   input  wire period_t  latched,
   input  wire           dir_changed,
   input  wire           period_valid,
   input  wire           row_end,       // row done, levels settled
   input  wire pos_t     row_pos,       // table position after the row
   input  wire err_cnt_t row_err,       // table error count after the row
   output int            errors,
   output int            checks
);

   logic     last_a, last_b;        // previous pin samples
   quad_t    fcode;                 // model of the filtered code
   pos_t     mpos;                  // model position
   err_cnt_t merr;                  // model error count
   logic     mdir;                  // model direction level
   logic     step_p [4];            // 3 cycles from filter to decoder outputs
   logic     qerr_p [4];
   logic     dir_p  [4];
   pos_t     pos_p  [4];
   err_cnt_t errc_p [4];
   int       m;                     // negedges since reset release
   int       last_step_m;           // negedge of the last step pulse
   logic     has_step, ref_dir;     // reference step and its dir
   logic     pstep, pdir;           // step seen one negedge ago
   logic     mpv, mdc;              // period_valid, dir_changed
   period_t  mlat, mcnt, mper;      // latched, running, reported

   initial begin
      errors = 0;
      checks = 0;
   end

   // Gray order position of a code, forward is +1
   function automatic int gray_pos(input quad_t c);
      case (c)
         2'b00:   return 0;
         2'b10:   return 1;
         2'b11:   return 2;
         default: return 3;
      endcase
   endfunction

   function automatic period_t sat_count(input int n);
      if (n >= int'(period_max)) return period_max;
      return period_t'(n);
   endfunction

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("error %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic clear_model();
      last_a = 1'b0;  // pins and sync flops are 0 in reset
      last_b = 1'b0;
      fcode  = '0;
      mpos   = '0;
      merr   = '0;
      mdir   = 1'b0;
      for (int i = 0; i < 4; i++) begin
         step_p[i] = 1'b0;
         qerr_p[i] = 1'b0;
         dir_p[i]  = 1'b0;
         pos_p[i]  = '0;
         errc_p[i] = '0;
      end
      m = 0;
      last_step_m = 0;  // running count starts at the first edge out of reset
      {has_step, ref_dir, pstep, pdir, mpv, mdc} = '0;
      mlat = '0;
      mcnt = '0;
   endtask

   // ----------------------------------------
   // model and compare on the falling edge
   // ----------------------------------------
   always @(negedge clk_fast) begin : watch
      quad_t nf;
      logic  nstep, nqerr;
      int    diff;
      if (!reset) begin
         clear_model();
      end else begin
         m = m + 1;
         nf = fcode;
         if (a == last_a) nf[1] = a;  // two equal samples pass the filter
         if (b == last_b) nf[0] = b;
         last_a = a;
         last_b = b;
         nstep = 1'b0;
         nqerr = 1'b0;
         if (nf != fcode) begin
            diff = (gray_pos(nf) - gray_pos(fcode) + 4) % 4;
            if (diff == 1) begin
               nstep = 1'b1;
               mdir  = 1'b1;
               mpos  = mpos + pos_t'(1);
            end else if (diff == 3) begin
               nstep = 1'b1;
               mdir  = 1'b0;
               mpos  = mpos - pos_t'(1);
            end else begin
               nqerr = 1'b1;  // both lines moved
               if (merr != err_max) merr = merr + err_cnt_t'(1);
            end
            fcode = nf;
         end
         for (int i = 3; i > 0; i--) begin
            step_p[i] = step_p[i-1];
            qerr_p[i] = qerr_p[i-1];
            dir_p[i]  = dir_p[i-1];
            pos_p[i]  = pos_p[i-1];
            errc_p[i] = errc_p[i-1];
         end
         step_p[0] = nstep;
         qerr_p[0] = nqerr;
         dir_p[0]  = mdir;
         pos_p[0]  = mpos;
         errc_p[0] = merr;

         // period side follows the step by one cycle
         mpv = 1'b0;
         if (pstep) begin
            if (has_step) begin
               mpv = 1'b1;
               if (pdir != ref_dir) begin
                  mlat = period_max;  // reversal marker
                  mdc  = 1'b1;
               end else begin
                  mlat = sat_count(m - 1 - last_step_m);  // step spacing
                  mdc  = 1'b0;
               end
            end
            has_step    = 1'b1;
            ref_dir     = pdir;
            last_step_m = m - 1;
         end
         mcnt = sat_count(m - last_step_m - 1);  // cycles since that step
         mper = (mlat > mcnt) ? mlat : mcnt;

         compare_value("step", 32'(step_p[3]), 32'(step));
         compare_value("quad_error", 32'(qerr_p[3]), 32'(quad_error));
         compare_value("dir", 32'(dir_p[3]), 32'(dir));
         compare_value("position", 32'(pos_p[3]), 32'(position));
         compare_value("err_count", 32'(errc_p[3]), 32'(err_count));
         compare_value("period_valid", 32'(mpv), 32'(period_valid));
         compare_value("latched", 32'(mlat), 32'(latched));
         compare_value("dir_changed", 32'(mdc), 32'(dir_changed));
         compare_value("period", 32'(mper), 32'(period));
         if (period < latched) begin
            errors++;
            $display("reported period fell below the latched period at %0t", $time);
         end
         if (row_end) begin  // table values at the end of a row
            compare_value("position(row)", 32'(row_pos), 32'(position));
            compare_value("err_count(row)", 32'(row_err), 32'(err_count));
         end
         pstep = step_p[3];
         pdir  = dir_p[3];
      end
   end

endmodule

`default_nettype wire

// File: tb_enc_channel.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// testbench for one encoder channel
// ----------------------------------------

module tb_enc_channel import enc_pkg::*; ();

   localparam int n_rows = 10;

   // ----------------------------------------
   // table: steps, fwd, spacing, glitch,
   // illegal, position and errors after row
   // ----------------------------------------
   int tab_steps   [n_rows] = '{6, 5, 4, 12, 3, 2, 7, 1, 1, 1};
   int tab_fwd     [n_rows] = '{1, 1, 0, 0, 1, 1, 0, 1, 0, 1};
   int tab_space   [n_rows] = '{6, 10, 8, 5, 4, 300, 7, 9, 4, 6};
   int tab_glitch  [n_rows] = '{0, 1, 0, 1, 0, 0, 1, 0, 0, 0};
   int tab_illegal [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1};
   int tab_pos     [n_rows] = '{6, 11, 7, -5, -2, 0, -7, -6, -7, -7};
   int tab_err     [n_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1};

   logic     clk_fast, reset, a, b;
   logic     step, dir, quad_error, dir_changed, period_valid;
   pos_t     position;
   err_cnt_t err_count;
   period_t  period, latched;
   logic     row_end;           // table check strobe for the checker
   pos_t     row_pos;
   err_cnt_t row_err;
   int       errors, checks;
   quad_t    cur_code;          // code now on the pins
   logic [31:0] lfsr;
   int       limit;
   int       cycle_cnt = 0;

   enc_channel_top dut_i (
      .clk_fast(clk_fast), .reset(reset), .a(a), .b(b),
      .step(step), .dir(dir), .position(position),
      .quad_error(quad_error), .err_count(err_count),
      .period(period), .latched(latched),
      .dir_changed(dir_changed), .period_valid(period_valid)
   );

   enc_checker chk_i (
      .clk_fast(clk_fast), .reset(reset), .a(a), .b(b),
      .step(step), .dir(dir), .position(position),
      .quad_error(quad_error), .err_count(err_count),
      .period(period), .latched(latched),
      .dir_changed(dir_changed), .period_valid(period_valid),
      .row_end(row_end), .row_pos(row_pos), .row_err(row_err),
      .errors(errors), .checks(checks)
   );

   always #4 clk_fast = ~clk_fast;  // 8 ns period

   always @(posedge clk_fast) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= limit) begin
         $display("timeout: test did not finish within %0d cycles", limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // glitch offset in 2 .. spacing-2, clear of both real edges
   function automatic int pick_offset(input int spacing);
      logic [3:0] v;
      v = '0;
      for (int i = 0; i < 4; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[2:0], lfsr[0]};  // one step per bit
      end
      return 2 + int'(v) % (spacing - 3);
   endfunction

   function automatic quad_t gray_next(input quad_t c, input int fwd);
      case (c)
         2'b00:   return (fwd != 0) ? 2'b10 : 2'b01;
         2'b10:   return (fwd != 0) ? 2'b11 : 2'b00;
         2'b11:   return (fwd != 0) ? 2'b01 : 2'b10;
         default: return (fwd != 0) ? 2'b00 : 2'b11;
      endcase
   endfunction

   function automatic int run_limit();
      int total;
      total = 200;  // margin for reset, latency and drain
      for (int r = 0; r < n_rows; r++) begin
         total += tab_steps[r] * tab_space[r] + 6;
      end
      return total;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_fast);
      #1;  // drive just after the edge
   endtask

   task automatic apply_code(input quad_t c);
      a = c[1];
      b = c[0];
   endtask

   // one pin change after spacing cycles, optional one cycle glitch
   task automatic move_to(input quad_t next, input int spacing, input int glitch);
      quad_t still;
      int    off;
      if (glitch != 0) begin
         still = ~(next ^ cur_code);  // line that stays put
         off   = pick_offset(spacing);
         wait_cycles(off);
         apply_code(cur_code ^ still);
         wait_cycles(1);
         apply_code(cur_code);
         wait_cycles(spacing - off - 1);
      end else begin
         wait_cycles(spacing);
      end
      cur_code = next;
      apply_code(cur_code);
   endtask

   task automatic run_row(input int r);
      quad_t next;
      for (int i = 0; i < tab_steps[r]; i++) begin
         next = (tab_illegal[r] != 0) ? ~cur_code : gray_next(cur_code, tab_fwd[r]);
         move_to(next, tab_space[r], tab_glitch[r]);
      end
      wait_cycles(5);  // pin to position is 4 cycles
      row_pos = pos_t'(tab_pos[r]);
      row_err = err_cnt_t'(tab_err[r]);
      row_end = 1'b1;
      wait_cycles(1);
      row_end = 1'b0;
   endtask

   initial begin
      clk_fast = 1'b0;
      reset    = 1'b0;
      a        = 1'b0;
      b        = 1'b0;
      row_end  = 1'b0;
      row_pos  = '0;
      row_err  = '0;
      cur_code = '0;
      lfsr     = 32'h43846309;
      limit    = run_limit();
      repeat (5) @(posedge clk_fast);
      #1 reset = 1'b1;
      for (int r = 0; r < n_rows; r++) begin
         run_row(r);
      end
      wait_cycles(10);  // let the period side settle
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
enc_pkg.sv
enc_input_sync.sv
enc_quad_decoder.sv
enc_period_counter.sv
enc_channel_top.sv
enc_checker.sv
tb_enc_channel.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the encoder channel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f build.f \
   --top-module tb_enc_channel \
   -o sim_enc

if ! ./obj_dir/sim_enc > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error status"
   exit 1
fi
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "result: fail"
   exit 1
fi
echo "result: pass"
